//--- flist.f
logic/rv32i_types.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/mem.sv
logic/forward.sv
logic/cpu.sv
tb/cpu_sva.sv
tb/tb_cpu.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
	-f flist.f --top-module tb_cpu -o sim_tb_cpu
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

out=$(./obj_dir/sim_tb_cpu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1

//--- tb/tb_cpu.sv
module tb_cpu;

localparam int PROG_LEN = 36;
localparam int NUM_STORES = 13;
localparam int TAIL_CYCLES = 40;
localparam logic [31:0] NOP = 32'h0000_0013;

logic clk;
logic rst;
logic read_a;
logic [31:0] address_a;
logic resp_a;
logic [31:0] rdata_a;
logic read_b;
logic write;
logic [3:0] wmask;
logic [31:0] address_b;
logic [31:0] wdata;
logic resp_b;
logic [31:0] rdata_b;

logic [31:0] prog [PROG_LEN];
logic [31:0] ram [64];
logic [31:0] exp_addr [NUM_STORES];
logic [31:0] exp_data [NUM_STORES];
logic [31:0] lfsr;
logic [1:0] wait_a;
logic [1:0] wait_b;
int errors;
int stores_seen;

cpu #(
	.RESET_PC(32'h0000_0000)
) i_dut (
	.clk,
	.rst,
	.read_a,
	.address_a,
	.resp_a,
	.rdata_a,
	.read_b,
	.write,
	.wmask,
	.address_b,
	.wdata,
	.resp_b,
	.rdata_b
);

bind cpu cpu_sva i_sva (
	.clk,
	.rst,
	.read_a,
	.address_a,
	.resp_a,
	.read_b,
	.write,
	.wmask,
	.address_b,
	.wdata,
	.resp_b
);

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_br(input logic [12:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

task automatic check_value(input string name, input logic [31:0] got,
	input logic [31:0] exp);
	if (got !== exp) begin
		errors++;
		$display("ERROR %s: got %h, expected %h", name, got, exp);
	end
endtask

task automatic finish_run();
	$display("Errors: %0d, stores seen: %0d of %0d", errors, stores_seen, NUM_STORES);
	if (errors == 0) begin
		$display("TESTS PASSED");
	end else begin
		$display("TESTS FAILED");
	end
	$finish;
endtask

initial begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

initial begin
	// lui and immediate ALU ops
	prog[0] = {20'h12345, 5'd1, 7'b0110111};
	prog[1] = enc_sw(12'd0, 5'd1, 5'd0);
	prog[2] = enc_i(12'hffb, 5'd0, 3'b000, 5'd2, 7'b0010011);
	prog[3] = enc_sw(12'd4, 5'd2, 5'd0);
	prog[4] = enc_i(12'd1, 5'd2, 3'b010, 5'd3, 7'b0010011);
	prog[5] = enc_sw(12'd8, 5'd3, 5'd0);
	prog[6] = enc_i(12'h0ff, 5'd1, 3'b100, 5'd4, 7'b0010011);
	prog[7] = enc_sw(12'd12, 5'd4, 5'd0);
	prog[8] = enc_i(12'h0f0, 5'd2, 3'b111, 5'd5, 7'b0010011);
	prog[9] = enc_sw(12'd16, 5'd5, 5'd0);
	prog[10] = enc_i(12'h7f0, 5'd3, 3'b110, 5'd6, 7'b0010011);
	prog[11] = enc_sw(12'd20, 5'd6, 5'd0);
	// Back-to-back register ops through the forwarding paths
	prog[12] = enc_i(12'd100, 5'd0, 3'b000, 5'd8, 7'b0010011);
	prog[13] = enc_i(12'd30, 5'd0, 3'b000, 5'd9, 7'b0010011);
	prog[14] = enc_r(7'b0100000, 5'd9, 5'd8, 3'b000, 5'd10);
	prog[15] = enc_r(7'b0000000, 5'd10, 5'd2, 3'b010, 5'd11);
	prog[16] = enc_r(7'b0000000, 5'd11, 5'd10, 3'b100, 5'd12);
	prog[17] = enc_r(7'b0000000, 5'd8, 5'd12, 3'b110, 5'd13);
	prog[18] = enc_r(7'b0000000, 5'd10, 5'd13, 3'b111, 5'd14);
	prog[19] = enc_sw(12'd24, 5'd14, 5'd0);
	prog[20] = enc_sw(12'd28, 5'd13, 5'd0);
	// Store, load back, dependent add
	prog[21] = enc_sw(12'd32, 5'd10, 5'd0);
	prog[22] = enc_i(12'd32, 5'd0, 3'b010, 5'd15, 7'b0000011);
	prog[23] = enc_r(7'b0000000, 5'd8, 5'd15, 3'b000, 5'd16);
	prog[24] = enc_sw(12'd36, 5'd16, 5'd0);
	// Taken branches skip a store while the others fall through
	prog[25] = enc_br(13'd8, 5'd8, 5'd8, 3'b000);
	prog[26] = enc_sw(12'd40, 5'd1, 5'd0);
	prog[27] = enc_br(13'd8, 5'd9, 5'd8, 3'b001);
	prog[28] = enc_sw(12'd44, 5'd1, 5'd0);
	prog[29] = enc_br(13'd8, 5'd9, 5'd8, 3'b000);
	prog[30] = enc_sw(12'd48, 5'd9, 5'd0);
	prog[31] = enc_br(13'd8, 5'd8, 5'd8, 3'b001);
	prog[32] = enc_sw(12'd52, 5'd8, 5'd0);
	// x0 stays zero
	prog[33] = enc_i(12'd55, 5'd0, 3'b000, 5'd0, 7'b0010011);
	prog[34] = enc_sw(12'd56, 5'd0, 5'd0);
	prog[35] = enc_br(13'd0, 5'd0, 5'd0, 3'b000);

	exp_addr[0] = 32'h00;
	exp_data[0] = 32'h1234_5000;
	exp_addr[1] = 32'h04;
	exp_data[1] = 32'hffff_fffb;
	exp_addr[2] = 32'h08;
	exp_data[2] = 32'h0000_0001;
	exp_addr[3] = 32'h0c;
	exp_data[3] = 32'h1234_50ff;
	exp_addr[4] = 32'h10;
	exp_data[4] = 32'h0000_00f0;
	exp_addr[5] = 32'h14;
	exp_data[5] = 32'h0000_07f1;
	exp_addr[6] = 32'h18;
	exp_data[6] = 32'h0000_0046;
	exp_addr[7] = 32'h1c;
	exp_data[7] = 32'h0000_0067;
	exp_addr[8] = 32'h20;
	exp_data[8] = 32'h0000_0046;
	exp_addr[9] = 32'h24;
	exp_data[9] = 32'h0000_00aa;
	exp_addr[10] = 32'h30;
	exp_data[10] = 32'h0000_001e;
	exp_addr[11] = 32'h34;
	exp_data[11] = 32'h0000_0064;
	exp_addr[12] = 32'h38;
	exp_data[12] = 32'h0000_0000;

	for (int i = 0; i < 64; i++) begin
		ram[i] = 32'h0;
	end
	lfsr = 32'hf84a_2fbc;
	wait_a = 2'd0;
	wait_b = 2'd0;
	errors = 0;
	stores_seen = 0;
	rst = 1'b1;
	resp_a = 1'b0;
	rdata_a = NOP;
	resp_b = 1'b0;
	rdata_b = 32'h0;

	repeat (4) @(posedge clk);
	rst <= 1'b0;

	for (int i = 0; i < NUM_STORES; i++) begin
		@(posedge clk);
		while (!(write && resp_b)) begin
			@(posedge clk);
		end
		check_value("address_b", address_b, exp_addr[i]);
		check_value("wdata", wdata, exp_data[i]);
		check_value("wmask", {28'd0, wmask}, 32'h0000_000f);
		stores_seen++;
	end

	// The program now spins on its last branch and must store nothing more
	repeat (TAIL_CYCLES) begin
		@(posedge clk);
		if (write && resp_b) begin
			errors++;
			$display("ERROR an extra store to address %h appeared after the last one",
				address_b);
		end
	end
	finish_run();
end

// Both ports in one process so the shared LFSR is stepped in a fixed order
always @(posedge clk) begin
	logic [1:0] draw;
	if (rst) begin
		resp_a <= 1'b0;
		resp_b <= 1'b0;
	end else begin
		resp_a <= 1'b0;
		resp_b <= 1'b0;
		if (read_a && !resp_a) begin
			if (wait_a == 2'd0) begin
				resp_a <= 1'b1;
				rdata_a <= (address_a[31:2] < PROG_LEN) ? prog[address_a[7:2]] : NOP;
				lfsr = lfsr_next(lfsr);
				draw[0] = lfsr[0];
				lfsr = lfsr_next(lfsr);
				draw[1] = lfsr[0];
				wait_a <= draw;
			end else begin
				wait_a <= wait_a - 2'd1;
			end
		end
		if ((read_b || write) && !resp_b) begin
			if (wait_b == 2'd0) begin
				resp_b <= 1'b1;
				if (write) begin
					ram[address_b[7:2]] <= wdata;
				end else begin
					rdata_b <= ram[address_b[7:2]];
				end
				lfsr = lfsr_next(lfsr);
				draw[0] = lfsr[0];
				lfsr = lfsr_next(lfsr);
				draw[1] = lfsr[0];
				wait_b <= draw;
			end else begin
				wait_b <= wait_b - 2'd1;
			end
		end
	end
end

initial begin
	#(PROG_LEN * 3 * 8 * 4);
	$display("Timeout: only %0d of %0d expected stores were seen before the time ran out",
		stores_seen, NUM_STORES);
	$display("Errors: %0d, stores seen: %0d of %0d", errors, stores_seen, NUM_STORES);
	$display("TESTS FAILED");
	$finish;
end

endmodule : tb_cpu

//--- tb/cpu_sva.sv
module cpu_sva
(
	input logic clk,
	input logic rst,
	input logic read_a,
	input logic [31:0] address_a,
	input logic resp_a,
	input logic read_b,
	input logic write,
	input logic [3:0] wmask,
	input logic [31:0] address_b,
	input logic [31:0] wdata,
	input logic resp_b
);

// Requests stay put until their response
a_port_a_hold: assert property (@(posedge clk) disable iff (rst)
	read_a && !resp_a |=> read_a && $stable(address_a))
	else $error("port A request changed before resp_a");

a_port_b_hold: assert property (@(posedge clk) disable iff (rst)
	(read_b || write) && !resp_b |=>
	$stable(read_b) && $stable(write) && $stable(address_b) && $stable(wdata))
	else $error("port B request changed before resp_b");

a_port_b_excl: assert property (@(posedge clk) disable iff (rst)
	!(read_b && write))
	else $error("read_b and write high together");

a_wmask_full: assert property (@(posedge clk) disable iff (rst)
	write |-> wmask == 4'hf)
	else $error("wmask not all ones on a store");

endmodule : cpu_sva

//--- logic/cpu.sv
module cpu
#(
	parameter rv32i_types::rv32i_word RESET_PC = 32'h0000_0000
)
(
	input logic clk,
	input logic rst,

	// port A
	output logic read_a,
	output rv32i_types::rv32i_word address_a,
	input logic resp_a,
	input rv32i_types::rv32i_word rdata_a,

	// port B
	output logic read_b,
	output logic write,
	output logic [3:0] wmask,
	output rv32i_types::rv32i_word address_b,
	output rv32i_types::rv32i_word wdata,
	input logic resp_b,
	input rv32i_types::rv32i_word rdata_b
);

rv32i_types::stage_regs dec_regs;
rv32i_types::stage_regs dx_regs;
rv32i_types::stage_regs exe_in;
rv32i_types::stage_regs xm_regs;
rv32i_types::stage_regs mw_regs;

rv32i_types::rv32i_word pc;
rv32i_types::rv32i_word redirect_pc;
logic fetch_valid;
logic fetch_wait;
logic mem_busy;
logic load_use;
logic redirect;
logic stall;
logic flush;
logic wb_ld;
logic [1:0] fwd_a;
logic [1:0] fwd_b;

assign fetch_wait = read_a && !resp_a;

// load_use is kept apart, it bubbles execute instead of freezing it
assign stall = mem_busy || fetch_wait;
assign flush = redirect || load_use;

// A held decode/execute entry must not be executed twice
always_comb begin
	exe_in = dx_regs;
	exe_in.valid = dx_regs.valid && !stall;
end

assign wb_ld = mw_regs.valid && mw_regs.ctrl.ld_regfile;

fetch #(
	.RESET_PC(RESET_PC)
) stage_one (
	.clk,
	.rst,
	.stall,
	.load_use,
	.redirect,
	.redirect_pc,
	.resp_a,
	.read_a,
	.address_a,
	.fetch_valid,
	.pc
);

decode stage_two (
	.clk,
	.rst,
	.hold(stall),
	.flush,
	.fetch_valid,
	.instruction(rdata_a),
	.pc,
	.wb_ld,
	.wb_rd(mw_regs.rd),
	.wb_data(mw_regs.result),
	.regs_out(dx_regs),
	.regs_comb(dec_regs)
);

execute stage_three (
	.clk,
	.rst,
	.stall(mem_busy),
	.regs_in(exe_in),
	.fwd_a,
	.fwd_b,
	.mem_result(xm_regs.result),
	.wb_result(mw_regs.result),
	.regs_out(xm_regs),
	.redirect,
	.redirect_pc
);

mem stage_four (
	.clk,
	.rst,
	.regs_in(xm_regs),
	.resp_b,
	.rdata_b,
	.read_b,
	.write,
	.wmask,
	.address_b,
	.wdata,
	.mem_busy,
	.regs_out(mw_regs)
);

forward forwarding_unit (
	.exe(dx_regs),
	.mem(xm_regs),
	.wb(mw_regs),
	.fwd_a,
	.fwd_b,
	.load_use_rs(dec_regs),
	.load_use
);

endmodule : cpu

//--- logic/forward.sv
module forward
(
	input rv32i_types::stage_regs exe,
	input rv32i_types::stage_regs mem,
	input rv32i_types::stage_regs wb,
	output logic [1:0] fwd_a,
	output logic [1:0] fwd_b,

	// entry currently in decode
	input rv32i_types::stage_regs load_use_rs,
	output logic load_use
);

// Nearest producer wins, x0 is never forwarded
function automatic logic [1:0] fwd_sel(
	input logic [4:0] rs,
	input rv32i_types::stage_regs near,
	input rv32i_types::stage_regs far
);
	if (rs == 5'd0) begin
		return 2'd0;
	end
	if (near.valid && near.ctrl.ld_regfile && near.rd == rs) begin
		return 2'd1;
	end
	if (far.valid && far.ctrl.ld_regfile && far.rd == rs) begin
		return 2'd2;
	end
	return 2'd0;
endfunction

assign fwd_a = fwd_sel(exe.rs1, mem, wb);
assign fwd_b = fwd_sel(exe.rs2, mem, wb);

// Load data only exists after the memory stage, one bubble is needed
assign load_use = exe.valid && exe.ctrl.mem_read && exe.rd != 5'd0 &&
	load_use_rs.valid &&
	(exe.rd == load_use_rs.rs1 || exe.rd == load_use_rs.rs2);

endmodule : forward

//--- logic/mem.sv
module mem
(
	input logic clk,
	input logic rst,
	input rv32i_types::stage_regs regs_in,

	// port B
	input logic resp_b,
	input rv32i_types::rv32i_word rdata_b,
	output logic read_b,
	output logic write,
	output logic [3:0] wmask,
	output rv32i_types::rv32i_word address_b,
	output rv32i_types::rv32i_word wdata,

	output logic mem_busy,
	output rv32i_types::stage_regs regs_out
);

// Request follows the held execute/memory entry, so it stays steady until resp_b
assign read_b = regs_in.valid && regs_in.ctrl.mem_read;
assign write = regs_in.valid && regs_in.ctrl.mem_write;

// Word stores only
assign wmask = {4{write}};

assign address_b = regs_in.result;
assign wdata = regs_in.rs2_data;

assign mem_busy = (read_b || write) && !resp_b;

// Output of this register is the writeback stage
always_ff @(posedge clk) begin
	if (rst) begin
		regs_out <= rv32i_types::NOP_REGS;
	end else if (!mem_busy) begin
		regs_out <= regs_in;
		if (read_b) begin
			regs_out.result <= rdata_b;
		end
	end
end

endmodule : mem

//--- logic/execute.sv
module execute
(
	input logic clk,
	input logic rst,
	input logic stall,
	input rv32i_types::stage_regs regs_in,
	input logic [1:0] fwd_a,
	input logic [1:0] fwd_b,
	input rv32i_types::rv32i_word mem_result,
	input rv32i_types::rv32i_word wb_result,

	output rv32i_types::stage_regs regs_out,
	output logic redirect,
	output rv32i_types::rv32i_word redirect_pc
);

rv32i_types::rv32i_word opnd_a;
rv32i_types::rv32i_word opnd_b;
rv32i_types::rv32i_word alu_b;
rv32i_types::rv32i_word alu_out;

function automatic rv32i_types::rv32i_word pick(
	input logic [1:0] sel,
	input rv32i_types::rv32i_word reg_val,
	input rv32i_types::rv32i_word mem_val,
	input rv32i_types::rv32i_word wb_val
);
	case (sel)
		2'd1: return mem_val;
		2'd2: return wb_val;
		default: return reg_val;
	endcase
endfunction

assign opnd_a = pick(fwd_a, regs_in.rs1_data, mem_result, wb_result);
assign opnd_b = pick(fwd_b, regs_in.rs2_data, mem_result, wb_result);
assign alu_b = regs_in.ctrl.alu_src_imm ? regs_in.imm : opnd_b;

// Loads and stores use the add path for the address
always_comb begin
	case (regs_in.ctrl.aluop)
		rv32i_types::alu_sub: alu_out = opnd_a - alu_b;
		rv32i_types::alu_slt: alu_out = {31'd0, $signed(opnd_a) < $signed(alu_b)};
		rv32i_types::alu_xor: alu_out = opnd_a ^ alu_b;
		rv32i_types::alu_or: alu_out = opnd_a | alu_b;
		rv32i_types::alu_and: alu_out = opnd_a & alu_b;
		default: alu_out = opnd_a + alu_b;
	endcase
end

// br_ne inverts the equality test
assign redirect = regs_in.valid && regs_in.ctrl.opcode == rv32i_types::op_br &&
	((opnd_a == opnd_b) != regs_in.ctrl.br_ne);
assign redirect_pc = regs_in.pc + regs_in.imm;

always_ff @(posedge clk) begin
	if (rst) begin
		regs_out <= rv32i_types::NOP_REGS;
	end else if (!stall) begin
		regs_out <= regs_in;
		regs_out.rs1_data <= opnd_a;
		// store data
		regs_out.rs2_data <= opnd_b;
		regs_out.result <= alu_out;
	end
end

endmodule : execute

//--- logic/decode.sv
module decode
(
	input logic clk,
	input logic rst,
	input logic hold,
	input logic flush,
	input logic fetch_valid,
	input rv32i_types::rv32i_word instruction,
	input rv32i_types::rv32i_word pc,

	// register file write port, from writeback
	input logic wb_ld,
	input logic [4:0] wb_rd,
	input rv32i_types::rv32i_word wb_data,

	output rv32i_types::stage_regs regs_out,
	output rv32i_types::stage_regs regs_comb
);

rv32i_types::rv32i_word regfile [32];
rv32i_types::rv32i_opcode opcode;
rv32i_types::alu_ops arith_op;
logic [2:0] funct3;
logic funct7_5;
rv32i_types::rv32i_word imm_i;
rv32i_types::rv32i_word imm_s;
rv32i_types::rv32i_word imm_b;
rv32i_types::rv32i_word imm_u;

// Write first, so an instruction retiring this cycle is seen here
function automatic rv32i_types::rv32i_word reg_read(input logic [4:0] idx);
	if (idx == 5'd0) begin
		return '0;
	end
	if (wb_ld && wb_rd == idx) begin
		return wb_data;
	end
	return regfile[idx];
endfunction

assign opcode = rv32i_types::rv32i_opcode'(instruction[6:0]);
assign funct3 = instruction[14:12];
assign funct7_5 = instruction[30];

assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
	instruction[30:25], instruction[11:8], 1'b0};
assign imm_u = {instruction[31:12], 12'h000};

always_comb begin
	case (funct3)
		3'b010: arith_op = rv32i_types::alu_slt;
		3'b100: arith_op = rv32i_types::alu_xor;
		3'b110: arith_op = rv32i_types::alu_or;
		3'b111: arith_op = rv32i_types::alu_and;
		default: begin
			if (opcode == rv32i_types::op_reg && funct7_5) begin
				arith_op = rv32i_types::alu_sub;
			end else begin
				arith_op = rv32i_types::alu_add;
			end
		end
	endcase
end

// Unused source and destination fields stay x0 so they never look like hazards
always_comb begin
	regs_comb = rv32i_types::NOP_REGS;
	regs_comb.valid = fetch_valid;
	regs_comb.pc = pc;
	regs_comb.ctrl.opcode = opcode;
	regs_comb.rs1 = instruction[19:15];
	regs_comb.imm = imm_i;
	case (opcode)
		rv32i_types::op_lui: begin
			regs_comb.rs1 = 5'd0;
			regs_comb.rd = instruction[11:7];
			regs_comb.imm = imm_u;
			regs_comb.ctrl.alu_src_imm = 1'b1;
			regs_comb.ctrl.ld_regfile = 1'b1;
		end
		rv32i_types::op_imm: begin
			regs_comb.rd = instruction[11:7];
			regs_comb.ctrl.aluop = arith_op;
			regs_comb.ctrl.alu_src_imm = 1'b1;
			regs_comb.ctrl.ld_regfile = 1'b1;
		end
		rv32i_types::op_reg: begin
			regs_comb.rs2 = instruction[24:20];
			regs_comb.rd = instruction[11:7];
			regs_comb.ctrl.aluop = arith_op;
			regs_comb.ctrl.ld_regfile = 1'b1;
		end
		rv32i_types::op_load: begin
			regs_comb.rd = instruction[11:7];
			regs_comb.ctrl.alu_src_imm = 1'b1;
			regs_comb.ctrl.ld_regfile = 1'b1;
			regs_comb.ctrl.mem_read = 1'b1;
		end
		rv32i_types::op_store: begin
			regs_comb.rs2 = instruction[24:20];
			regs_comb.imm = imm_s;
			regs_comb.ctrl.alu_src_imm = 1'b1;
			regs_comb.ctrl.mem_write = 1'b1;
		end
		rv32i_types::op_br: begin
			regs_comb.rs2 = instruction[24:20];
			regs_comb.imm = imm_b;
			regs_comb.ctrl.br_ne = (funct3 == rv32i_types::bne);
		end
		default: begin
			regs_comb.rs1 = 5'd0;
		end
	endcase
	regs_comb.rs1_data = reg_read(regs_comb.rs1);
	regs_comb.rs2_data = reg_read(regs_comb.rs2);
end

always_ff @(posedge clk) begin
	if (wb_ld && wb_rd != 5'd0) begin
		regfile[wb_rd] <= wb_data;
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		regs_out <= rv32i_types::NOP_REGS;
	end else if (hold) begin
		// Producers keep retiring while this entry waits
		if (wb_ld && wb_rd != 5'd0 && wb_rd == regs_out.rs1) begin
			regs_out.rs1_data <= wb_data;
		end
		if (wb_ld && wb_rd != 5'd0 && wb_rd == regs_out.rs2) begin
			regs_out.rs2_data <= wb_data;
		end
	end else if (flush) begin
		regs_out <= rv32i_types::NOP_REGS;
	end else begin
		regs_out <= regs_comb;
	end
end

endmodule : decode

//--- logic/fetch.sv
module fetch
#(
	parameter rv32i_types::rv32i_word RESET_PC = 32'h0000_0000
)
(
	input logic clk,
	input logic rst,
	input logic stall,
	input logic load_use,
	input logic redirect,
	input rv32i_types::rv32i_word redirect_pc,

	// port A
	input logic resp_a,
	output logic read_a,
	output rv32i_types::rv32i_word address_a,

	output logic fetch_valid,
	output rv32i_types::rv32i_word pc
);

rv32i_types::rv32i_word pc_r;
logic req;
logic advance;

assign read_a = req;
assign address_a = pc_r;
assign pc = pc_r;

// A response that meets a taken branch belongs to the wrong path
assign fetch_valid = req && resp_a && !redirect;

// Anything the pipeline cannot take now is fetched again from the same pc
assign advance = fetch_valid && !stall && !load_use;

always_ff @(posedge clk) begin
	if (rst) begin
		req <= 1'b0;
		pc_r <= RESET_PC;
	end else begin
		// Request drops for one cycle after every response
		req <= !(req && resp_a);
		if (redirect) begin
			pc_r <= redirect_pc;
		end else if (advance) begin
			pc_r <= pc_r + 32'd4;
		end
	end
end

endmodule : fetch

//--- logic/rv32i_types.sv
package rv32i_types;

typedef logic [31:0] rv32i_word;

typedef enum logic [6:0] {
	op_lui   = 7'b0110111,
	op_imm   = 7'b0010011,
	op_reg   = 7'b0110011,
	op_load  = 7'b0000011,
	op_store = 7'b0100011,
	op_br    = 7'b1100011
} rv32i_opcode;

typedef enum logic [2:0] {
	alu_add,
	alu_sub,
	alu_slt,
	alu_xor,
	alu_or,
	alu_and
} alu_ops;

typedef enum logic [2:0] {
	beq = 3'b000,
	bne = 3'b001
} branch_funct3;

typedef struct packed {
	rv32i_opcode opcode;
	alu_ops aluop;
	logic alu_src_imm;
	logic ld_regfile;
	logic mem_read;
	logic mem_write;
	logic br_ne;
} ctrl_word;

// One pipeline entry, carried from decode to writeback
typedef struct packed {
	logic valid;
	rv32i_word pc;
	ctrl_word ctrl;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rd;
	rv32i_word rs1_data;
	rv32i_word rs2_data;
	rv32i_word imm;
	rv32i_word result;
} stage_regs;

localparam ctrl_word NOP_CTRL = '{
	opcode: op_imm,
	aluop: alu_add,
	alu_src_imm: 1'b0,
	ld_regfile: 1'b0,
	mem_read: 1'b0,
	mem_write: 1'b0,
	br_ne: 1'b0
};

localparam stage_regs NOP_REGS = '{
	valid: 1'b0,
	pc: '0,
	ctrl: NOP_CTRL,
	rs1: '0,
	rs2: '0,
	rd: '0,
	rs1_data: '0,
	rs2_data: '0,
	imm: '0,
	result: '0
};

endpackage : rv32i_types
